// File: design/div_pkg.sv
package div_pkg;

    // ----------------------------------------------------------
    // Pipeline fields
    // ----------------------------------------------------------

    typedef logic [3:0] unit_t;                 // Execution unit select
    typedef logic [4:0] subop_t;                // Operation subtype field

    localparam unit_t UNIT_DIV = 4'd2;          // Divide unit code

    // ----------------------------------------------------------
    // Divide operations
    // ----------------------------------------------------------

    // Unknown subtypes are decoded as DIV_WU by the operand latch
    typedef enum subop_t {
        DIV_W  = 5'd0,                          // Signed quotient
        MOD_W  = 5'd1,                          // Signed remainder
        DIV_WU = 5'd2,                          // Unsigned quotient
        MOD_WU = 5'd3                           // Unsigned remainder
    } div_op_e;

    // ----------------------------------------------------------
    // Engine FSM
    // ----------------------------------------------------------

    typedef enum logic [2:0] {
        IDLE    = 3'd0,                         // Waiting for start
        LOAD    = 3'd1,                         // Copy magnitudes
        ALIGN   = 3'd2,                         // Normalize divisor
        ITERATE = 3'd3,                         // Shift-subtract loop
        FINISH  = 3'd4                          // Sign fix and result
    } div_state_e;

endpackage

// File: design/msb_locator.sv
`timescale 1ns/1ns

module msb_locator #(
    parameter WIDTH = 32
)(
    input  logic [WIDTH-1:0]         din,
    output logic [$clog2(WIDTH)-1:0] n
);

    localparam NW = $clog2(WIDTH);

    logic [WIDTH-1:0] word;                     // Active search window

    // ----------------------------------------------------------
    // Binary search, one bit of n per level
    // ----------------------------------------------------------

    // The window is kept zero above its current size, so shifting
    // right by the half size exposes exactly the upper half.
    always_comb
    begin
        word = din;
        n    = '0;
        for (int lvl = NW - 1; lvl >= 0; lvl--)
        begin
            if (|(word >> (1 << lvl)))
            begin
                n[lvl] = 1'b1;                  // Upper half holds the top one
                word   = word >> (1 << lvl);
            end
            else
            begin
                n[lvl] = 1'b0;
                word   = word & ~({WIDTH{1'b1}} << (1 << lvl));   // Keep lower half
            end
        end
    end

endmodule

// File: design/div_operand_latch.sv
`timescale 1ns/1ns

module div_operand_latch #(
    parameter WIDTH = 32
)(
    input  logic                clk,
    input  logic                arst_n,
    input  div_pkg::unit_t      unit_type,
    input  div_pkg::subop_t     sub_type,
    input  logic                issue_flush,
    input  logic                wb_stall,
    input  logic                busy,
    input  logic [WIDTH-1:0]    din1,
    input  logic [WIDTH-1:0]    din2,
    output logic                start,
    output div_pkg::div_op_e    op,
    output logic [WIDTH-1:0]    mag_dividend,
    output logic [WIDTH-1:0]    mag_divisor,
    output logic                sign_dividend,
    output logic                sign_divisor
);

    logic             issue;
    logic             is_signed;
    logic             neg_dividend;
    logic             neg_divisor;
    div_pkg::div_op_e op_dec;

    // ----------------------------------------------------------
    // Issue decode
    // ----------------------------------------------------------

    // Start still high means the engine has not yet seen this divide
    assign issue = (unit_type == div_pkg::UNIT_DIV) && !issue_flush &&
                   !wb_stall && !busy && !start;

    always_comb
    begin
        case (sub_type)
            div_pkg::DIV_W:  op_dec = div_pkg::DIV_W;
            div_pkg::MOD_W:  op_dec = div_pkg::MOD_W;
            div_pkg::MOD_WU: op_dec = div_pkg::MOD_WU;
            default:         op_dec = div_pkg::DIV_WU;
        endcase
    end

    assign is_signed    = (op_dec == div_pkg::DIV_W) || (op_dec == div_pkg::MOD_W);
    assign neg_dividend = is_signed && din1[WIDTH-1];
    assign neg_divisor  = is_signed && din2[WIDTH-1];

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            start <= 1'b0;
        else
            start <= issue;                     // One cycle pulse
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            op            <= op_dec;
            mag_dividend  <= neg_dividend ? -din1 : din1;
            mag_divisor   <= neg_divisor ? -din2 : din2;
            sign_dividend <= neg_dividend;
            sign_divisor  <= neg_divisor;
        end
    end

endmodule

// File: design/div_engine.sv
`timescale 1ns/1ns

module div_engine #(
    parameter WIDTH = 32
)(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     wb_flush,
    input  logic                     wb_stall,
    input  div_pkg::div_op_e         op,
    input  logic [WIDTH-1:0]         mag_dividend,
    input  logic [WIDTH-1:0]         mag_divisor,
    input  logic                     sign_dividend,
    input  logic                     sign_divisor,
    input  logic [$clog2(WIDTH)-1:0] msb_rem,
    input  logic [$clog2(WIDTH)-1:0] msb_div,
    output logic [WIDTH-1:0]         rem_work,
    output logic [WIDTH-1:0]         div_work,
    output logic                     busy,
    output logic                     done,
    output logic [WIDTH-1:0]         dout
);

    localparam CW = $clog2(WIDTH);

    div_pkg::div_state_e state;

    logic [CW-1:0]    cnt;                      // Remaining iterations minus one
    logic [WIDTH-1:0] quo_work;
    logic [CW:0]      align_diff;
    logic             skip_loop;
    logic [WIDTH:0]   trial;
    logic [WIDTH-1:0] quo_fix;
    logic [WIDTH-1:0] rem_fix;
    logic             is_mod;
    logic             abort;

    // ----------------------------------------------------------
    // Datapath arithmetic
    // ----------------------------------------------------------

    assign abort = wb_flush && !wb_stall;

    // Top bit set means the divisor's leading one sits above the dividend's
    assign align_diff = {1'b0, msb_rem} - {1'b0, msb_div};

    // Zero divisor or short dividend leaves quotient 0, remainder as loaded
    assign skip_loop = align_diff[CW] || (div_work == '0);

    // Borrow out in the top bit
    assign trial = {1'b0, rem_work} - {1'b0, div_work};

    // Unsigned ops arrive with both signs cleared
    assign quo_fix = (sign_dividend ^ sign_divisor) ? -quo_work : quo_work;
    assign rem_fix = sign_dividend ? -rem_work : rem_work;

    assign is_mod = (op == div_pkg::MOD_W) || (op == div_pkg::MOD_WU);

    // Held through the done cycle so no issue overlaps the result
    assign busy = (state != div_pkg::IDLE) || done;

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= div_pkg::IDLE;
            cnt   <= '0;
            done  <= 1'b0;
            dout  <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (abort)
                state <= div_pkg::IDLE;         // Drop the divide, no done
            else
            begin
                case (state)
                    div_pkg::IDLE:
                    begin
                        if (start)
                            state <= div_pkg::LOAD;
                    end
                    div_pkg::LOAD:
                    begin
                        state <= div_pkg::ALIGN;
                    end
                    div_pkg::ALIGN:
                    begin
                        if (skip_loop)
                            state <= div_pkg::FINISH;
                        else
                        begin
                            cnt   <= align_diff[CW-1:0];
                            state <= div_pkg::ITERATE;
                        end
                    end
                    div_pkg::ITERATE:
                    begin
                        if (cnt == '0)
                            state <= div_pkg::FINISH;   // Last quotient bit now
                        else
                            cnt <= cnt - 1'b1;
                    end
                    div_pkg::FINISH:
                    begin
                        dout  <= is_mod ? rem_fix : quo_fix;
                        done  <= 1'b1;
                        state <= div_pkg::IDLE;
                    end
                    default:
                    begin
                        state <= div_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------------------------
    // Working registers
    // ----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        case (state)
            div_pkg::LOAD:
            begin
                rem_work <= mag_dividend;
                div_work <= mag_divisor;
                quo_work <= '0;
            end
            div_pkg::ALIGN:
            begin
                // Line up the leading ones of divisor and dividend
                if (!skip_loop)
                    div_work <= div_work << align_diff[CW-1:0];
            end
            div_pkg::ITERATE:
            begin
                quo_work <= {quo_work[WIDTH-2:0], ~trial[WIDTH]};
                if (!trial[WIDTH])
                    rem_work <= trial[WIDTH-1:0];   // Restore by keeping old value
                div_work <= div_work >> 1;
            end
            default:
            begin
                quo_work <= quo_work;
            end
        endcase
    end

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ns

module div_unit #(
    parameter WIDTH = 32
)(
    input  logic             clk,
    input  logic             arst_n,
    input  div_pkg::unit_t   unit_type,
    input  div_pkg::subop_t  sub_type,
    input  logic             issue_flush,
    input  logic             wb_stall,
    input  logic             wb_flush,
    input  logic [WIDTH-1:0] din1,
    input  logic [WIDTH-1:0] din2,
    output logic             busy,
    output logic             done,
    output logic [WIDTH-1:0] dout
);

    localparam CW = $clog2(WIDTH);

    logic             start;
    div_pkg::div_op_e op;
    logic [WIDTH-1:0] mag_dividend;
    logic [WIDTH-1:0] mag_divisor;
    logic             sign_dividend;
    logic             sign_divisor;
    logic [WIDTH-1:0] rem_work;
    logic [WIDTH-1:0] div_work;
    logic [CW-1:0]    msb_rem;
    logic [CW-1:0]    msb_div;

    // ----------------------------------------------------------
    // Operand capture
    // ----------------------------------------------------------

    div_operand_latch #(.WIDTH(WIDTH)) latch0 (
        .clk(clk), .arst_n(arst_n),
        .unit_type(unit_type), .sub_type(sub_type),
        .issue_flush(issue_flush), .wb_stall(wb_stall), .busy(busy),
        .din1(din1), .din2(din2),
        .start(start), .op(op),
        .mag_dividend(mag_dividend), .mag_divisor(mag_divisor),
        .sign_dividend(sign_dividend), .sign_divisor(sign_divisor)
    );

    // ----------------------------------------------------------
    // Engine and its normalization locators
    // ----------------------------------------------------------

    div_engine #(.WIDTH(WIDTH)) engine0 (
        .clk(clk), .arst_n(arst_n), .start(start),
        .wb_flush(wb_flush), .wb_stall(wb_stall), .op(op),
        .mag_dividend(mag_dividend), .mag_divisor(mag_divisor),
        .sign_dividend(sign_dividend), .sign_divisor(sign_divisor),
        .msb_rem(msb_rem), .msb_div(msb_div),
        .rem_work(rem_work), .div_work(div_work),
        .busy(busy), .done(done), .dout(dout)
    );

    msb_locator #(.WIDTH(WIDTH)) loc_rem (.din(rem_work), .n(msb_rem));
    msb_locator #(.WIDTH(WIDTH)) loc_div (.din(div_work), .n(msb_div));

endmodule

// File: tests/div_vectors.svh
`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// Columns: subtype (5 bits), dividend, divisor, expected dout
// Subtypes: 0 signed quotient, 1 signed remainder, 2 unsigned quotient, 3 unsigned remainder
localparam int NUM_VEC = 22;

localparam logic [100:0] VEC_TABLE [NUM_VEC] = '{
    {5'd0, 32'h00000007, 32'h00000002, 32'h00000003},   // 7 / 2
    {5'd1, 32'h00000007, 32'h00000002, 32'h00000001},
    {5'd0, 32'hFFFFFFF9, 32'h00000002, 32'hFFFFFFFD},   // -7 / 2
    {5'd1, 32'hFFFFFFF9, 32'h00000002, 32'hFFFFFFFF},
    {5'd0, 32'h00000007, 32'hFFFFFFFE, 32'hFFFFFFFD},   // 7 / -2
    {5'd1, 32'h00000007, 32'hFFFFFFFE, 32'h00000001},
    {5'd0, 32'hFFFFFFF9, 32'hFFFFFFFE, 32'h00000003},   // -7 / -2
    {5'd1, 32'hFFFFFFF9, 32'hFFFFFFFE, 32'hFFFFFFFF},
    {5'd0, 32'h80000000, 32'hFFFFFFFF, 32'h80000000},   // Most negative / -1
    {5'd1, 32'h80000000, 32'hFFFFFFFF, 32'h00000000},
    {5'd2, 32'hF0000000, 32'h00000010, 32'h0F000000},
    {5'd3, 32'hFFFFFFFF, 32'h00010000, 32'h0000FFFF},
    {5'd2, 32'hFFFFFFFF, 32'h00010000, 32'h0000FFFF},
    {5'd2, 32'h00001234, 32'h80000000, 32'h00000000},   // Divisor above dividend
    {5'd3, 32'h00001234, 32'h80000000, 32'h00001234},
    {5'd0, 32'h00000064, 32'h00000000, 32'h00000000},   // Divide by zero
    {5'd1, 32'hFFFFFF9C, 32'h00000000, 32'hFFFFFF9C},
    {5'd2, 32'h80000001, 32'h00000000, 32'h00000000},
    {5'd3, 32'h80000001, 32'h00000000, 32'h80000001},
    {5'd0, 32'hFFFFFF9C, 32'h00000007, 32'hFFFFFFF2},   // -100 / 7
    {5'd1, 32'hFFFFFF9C, 32'h00000007, 32'hFFFFFFFE},
    {5'd9, 32'h00000064, 32'h00000007, 32'h0000000E}    // Unknown subtype acts unsigned
};

`endif

// File: tests/div_unit_tb.sv
`timescale 1ns/1ns

module div_unit_tb;

    localparam WIDTH        = 32;
    localparam TIMEOUT      = WIDTH + 6;        // Latency bound from issue edge
    localparam STALL_CYCLES = 6;

    logic             clk = 1'b0;
    logic             arst_n;
    div_pkg::unit_t   unit_type;
    div_pkg::subop_t  sub_type;
    logic             issue_flush;
    logic             wb_stall;
    logic             wb_flush;
    logic [WIDTH-1:0] din1;
    logic [WIDTH-1:0] din2;
    logic             busy;
    logic             done;
    logic [WIDTH-1:0] dout;

    int               value_errors;
    int               timeout_errors;
    logic [31:0]      lfsr_state;

    `include "div_vectors.svh"

    div_unit #(.WIDTH(WIDTH)) dut0 (
        .clk(clk), .arst_n(arst_n),
        .unit_type(unit_type), .sub_type(sub_type),
        .issue_flush(issue_flush), .wb_stall(wb_stall), .wb_flush(wb_flush),
        .din1(din1), .din2(din2),
        .busy(busy), .done(done), .dout(dout)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];       // Taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    // Truncating division, remainder follows the dividend
    function automatic logic [31:0] expected_result(input logic [4:0] op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] q;
        logic signed [63:0] r;
        logic               is_signed;
        logic               want_rem;
        is_signed = (op == 5'd0) || (op == 5'd1);
        want_rem  = (op == 5'd1) || (op == 5'd3);
        sa = is_signed ? {{32{a[31]}}, a} : {32'b0, a};
        sb = is_signed ? {{32{b[31]}}, b} : {32'b0, b};
        if (sb == 0)
        begin
            q = 0;
            r = sa;
        end
        else
        begin
            q = sa / sb;
            r = sa % sb;
        end
        return want_rem ? r[31:0] : q[31:0];
    endfunction

    // Returns right after the issue edge
    task automatic issue_div(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        unit_type <= div_pkg::UNIT_DIV;
        sub_type  <= op;
        din1      <= a;
        din2      <= b;
        @(posedge clk);
        unit_type <= 4'd0;
    endtask

    task automatic wait_done(input int limit, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            seen = (done === 1'b1);
        end
    endtask

    task automatic wait_busy(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 10)
        begin
            @(negedge clk);
            cycles++;
            seen = (busy === 1'b1);
        end
    endtask

    task automatic check_result(input logic seen, input logic [4:0] op,
                                input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] exp);
        if (!seen)
        begin
            $display("Timeout at %0t ns: done never came for subtype %0d, %h / %h",
                     $time, op, a, b);
            timeout_errors++;
        end
        else
        begin
            if (dout !== exp)
            begin
                $display("[FAIL] %0t ns: subtype %0d, %h / %h gave %h, expected %h",
                         $time, op, a, b, dout, exp);
                value_errors++;
            end
            @(negedge clk);
            if (busy !== 1'b0)
            begin
                $display("[FAIL] %0t ns: busy still high after done", $time);
                value_errors++;
            end
        end
    endtask

    task automatic run_div(input logic [4:0] op, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] exp);
        logic seen;
        issue_div(op, a, b);
        wait_done(TIMEOUT, seen);
        check_result(seen, op, a, b, exp);
    endtask

    task automatic check_idle(input int cycles, input logic [31:0] hold, input string what);
        logic bad;
        bad = 1'b0;
        for (int i = 0; i < cycles && !bad; i++)
        begin
            @(negedge clk);
            if (busy !== 1'b0 || done !== 1'b0 || dout !== hold)
            begin
                $display("[FAIL] %0t ns: %s, busy %b done %b dout %h, expected idle with %h",
                         $time, what, busy, done, dout, hold);
                value_errors++;
                bad = 1'b1;
            end
        end
    endtask

    task automatic check_no_issue(input div_pkg::unit_t ut, input logic flush,
                                  input logic stall, input string what);
        logic [31:0] hold;
        hold = dout;
        @(posedge clk);
        unit_type   <= ut;
        issue_flush <= flush;
        wb_stall    <= stall;
        sub_type    <= 5'd0;
        din1        <= 32'd100;
        din2        <= 32'd7;
        @(posedge clk);
        unit_type   <= 4'd0;
        issue_flush <= 1'b0;
        wb_stall    <= 1'b0;
        check_idle(12, hold, what);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial
    begin
        logic        seen;
        logic [31:0] hold;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0]  op;
        logic [100:0] entry;

        arst_n         = 1'b0;
        unit_type      = 4'd0;
        sub_type       = 5'd0;
        issue_flush    = 1'b0;
        wb_stall       = 1'b0;
        wb_flush       = 1'b0;
        din1           = '0;
        din2           = '0;
        value_errors   = 0;
        timeout_errors = 0;
        lfsr_state     = 32'h7b1d;

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || dout !== '0)
        begin
            $display("[FAIL] %0t ns: outputs not cleared by reset", $time);
            value_errors++;
        end

        for (int i = 0; i < NUM_VEC; i++)
        begin
            entry = VEC_TABLE[i];
            run_div(entry[100:96], entry[95:64], entry[63:32], entry[31:0]);
        end

        check_no_issue(4'd1, 1'b0, 1'b0, "other unit issued");
        check_no_issue(div_pkg::UNIT_DIV, 1'b1, 1'b0, "issue under issue_flush");
        check_no_issue(div_pkg::UNIT_DIV, 1'b0, 1'b1, "issue under wb_stall");

        // Stall while running must not hold up the loop
        issue_div(5'd2, 32'hFFFFFFFF, 32'h00000003);
        wb_stall <= 1'b1;
        repeat (STALL_CYCLES) @(posedge clk);
        wb_stall <= 1'b0;
        wait_done(TIMEOUT - STALL_CYCLES, seen);    // Rest of the bound from issue
        check_result(seen, 5'd2, 32'hFFFFFFFF, 32'h00000003, 32'h55555555);

        // Flush in the middle of a 32 step divide
        hold = dout;
        issue_div(5'd2, 32'hFFFFFFFF, 32'h00000001);
        wait_busy(seen);
        if (!seen)
        begin
            $display("Timeout at %0t ns: busy never rose before flush", $time);
            timeout_errors++;
        end
        repeat (3) @(posedge clk);
        wb_flush <= 1'b1;
        @(posedge clk);
        wb_flush <= 1'b0;
        check_idle(WIDTH + 8, hold, "after wb_flush");
        run_div(5'd1, 32'h80000000, 32'h00000003, 32'hFFFFFFFE);

        for (int n = 0; n < 200; n++)
        begin
            take_bits(2, r);
            op = {3'b0, r[1:0]};
            take_bits(32, a);
            take_bits(32, b);
            take_bits(5, r);
            b = b >> r[4:0];                    // Spread divisor sizes
            take_bits(3, r);
            if (r[2:0] == 3'd0)
                b = '0;
            run_div(op, a, b, expected_result(op, a, b));
        end

        $display("Closing report: %0d value errors, %0d timeouts",
                 value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+tests
design/div_pkg.sv
design/msb_locator.sv
design/div_operand_latch.sv
design/div_engine.sv
design/div_unit.sv
tests/div_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass only when the testbench reports success
cd "$(dirname "$0")" && \
verilator --binary --timing -Wno-fatal -f src.f --top-module div_unit_tb -o div_sim && \
./obj_dir/div_sim | tee /dev/stderr | grep -qx "Test OK" && \
echo "Simulation passed" || \
{ echo "Simulation failed"; exit 1; }
